// ==== mul_macros.svh ====
//----------------------------------------------------------------------------
// Multiply unit register map and fixed sizes
// APB offsets, address width and the number of 8x8 lanes
//----------------------------------------------------------------------------
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

`define MUL_ADDR_W 5                 // APB address width
`define MUL_LANES  4                 // Four 8x8 lanes make one 16x16 product

`define MUL_REG_CTRL        5'h00    // bit0 start, bit1 is_simd
`define MUL_REG_SIGN        5'h04    // bits 1:0 is_signed, bits 7:2 simd_signed
`define MUL_REG_OPS         5'h08
`define MUL_REG_SIMD_OPS    5'h0C    // Lane 2 pair on top, lane 3 pair below
`define MUL_REG_STATUS      5'h10    // bit0 busy, bit1 done
`define MUL_REG_RESULT      5'h14
`define MUL_REG_SIMD_RESULT 5'h18

`endif

// ==== mul_pkg.sv ====
//----------------------------------------------------------------------------
// Multiply unit types
// The operand word is one register read as scalar or SIMD operands
//----------------------------------------------------------------------------
`default_nettype none

package mul_pkg;

    // Scalar view: two 16-bit operands
    // SIMD view: lane 0 and lane 1 byte pairs, lane 0 in the upper half
    typedef union packed {
        struct packed {
            logic [15:0] multiplicand;
            logic [15:0] multiplier;
        } scalar;
        struct packed {
            logic [7:0] mcand0;
            logic [7:0] mplier0;
            logic [7:0] mcand1;
            logic [7:0] mplier1;
        } simd;
    } op_word_t;

endpackage

`default_nettype wire

// ==== lane_if.sv ====
//----------------------------------------------------------------------------
// One 8x8 multiplier lane
// Request side is driven by the issuer, result side by the lane
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface lane_if;

    logic        start;          // One-cycle pulse, operands captured here
    logic [7:0]  multiplicand;
    logic [7:0]  multiplier;
    logic [1:0]  is_signed;      // bit1 multiplicand, bit0 multiplier
    logic        finished;       // High for one cycle, two cycles after start
    logic [15:0] product;        // Held until the next job ends

    modport issuer (
        output start, multiplicand, multiplier, is_signed,
        input  finished, product
    );

    modport lane (
        input  start, multiplicand, multiplier, is_signed,
        output finished, product
    );

endinterface

`default_nettype wire

// ==== mul8.sv ====
//----------------------------------------------------------------------------
// 8x8 lane multiplier, signed or unsigned per operand
// Stage 1 forms four 4x4 vedic partials of the magnitudes, stage 2 sums
// them, restores the sign and raises finished for one cycle
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mul8 (
    input  logic CLK,
    input  logic rst_n,
    lane_if.lane lane
);

    logic        neg_a;
    logic        neg_b;
    logic [7:0]  mag_a;
    logic [7:0]  mag_b;
    logic [7:0]  pp_s1 [4];
    logic        neg_s1;
    logic        valid_s1;
    logic [15:0] sum_s2;

    // Vertical and crosswise on 2-bit digits
    function automatic logic [7:0] vedic4(input logic [3:0] x, input logic [3:0] y);
        logic [3:0] hh;
        logic [3:0] hl;
        logic [3:0] lh;
        logic [3:0] ll;
        hh = x[3:2] * y[3:2];
        hl = x[3:2] * y[1:0];
        lh = x[1:0] * y[3:2];
        ll = x[1:0] * y[1:0];
        vedic4 = {hh, 4'b0} + {2'b0, hl, 2'b0} + {2'b0, lh, 2'b0} + {4'b0, ll};
    endfunction

    // A signed operand with its top bit set is negative, -128 still fits 8 bits
    always_comb begin
        neg_a = lane.is_signed[1] & lane.multiplicand[7];
        neg_b = lane.is_signed[0] & lane.multiplier[7];
        mag_a = neg_a ? (~lane.multiplicand + 8'd1) : lane.multiplicand;
        mag_b = neg_b ? (~lane.multiplier + 8'd1) : lane.multiplier;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= lane.start;
        end
    end

    always_ff @(posedge CLK) begin
        if (lane.start) begin
            pp_s1[0] <= vedic4(mag_a[7:4], mag_b[7:4]);   // high x high
            pp_s1[1] <= vedic4(mag_a[7:4], mag_b[3:0]);
            pp_s1[2] <= vedic4(mag_a[3:0], mag_b[7:4]);
            pp_s1[3] <= vedic4(mag_a[3:0], mag_b[3:0]);   // low x low
            neg_s1   <= neg_a ^ neg_b;
        end
    end

    // Cross terms sit 4 bits up, the high partial 8 bits up
    assign sum_s2 = {pp_s1[0], 8'b0}
                  + {4'b0, pp_s1[1], 4'b0}
                  + {4'b0, pp_s1[2], 4'b0}
                  + {8'b0, pp_s1[3]};

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            lane.finished <= 1'b0;
        end else begin
            lane.finished <= valid_s1;
        end
    end

    always_ff @(posedge CLK) begin
        if (valid_s1) begin
            lane.product <= neg_s1 ? (~sum_s2 + 16'd1) : sum_s2;
        end
    end

endmodule

`default_nettype wire

// ==== vedic_mul16.sv ====
//----------------------------------------------------------------------------
// 16x16 vedic multiplier on four 8x8 lanes
// Scalar mode recombines the lane products into one 32-bit product, SIMD
// mode returns four independent 16-bit lane products
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "mul_macros.svh"

module vedic_mul16 (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              start,
    input  logic              is_simd,
    input  logic [1:0]        is_signed,
    input  logic [5:0]        simd_signed,
    input  mul_pkg::op_word_t ops,
    input  logic [31:0]       simd_ops,
    output logic              finished,
    output logic [31:0]       product,
    output logic [31:0]       simd_product
);

    logic [7:0]            mcand    [`MUL_LANES];
    logic [7:0]            mplier   [`MUL_LANES];
    logic [1:0]            lane_sgn [`MUL_LANES];
    logic [15:0]           pp       [`MUL_LANES];
    logic [`MUL_LANES-1:0] lane_done;
    logic                  job_simd;
    logic [1:0]            job_signed;
    logic [31:0]           cross_hl;
    logic [31:0]           cross_lh;
    logic [31:0]           scalar_sum;

    lane_if lanes [`MUL_LANES] ();

    always_comb begin
        if (is_simd) begin
            // Each lane gets its own byte pair and sign field
            mcand[0]    = ops.simd.mcand0;
            mplier[0]   = ops.simd.mplier0;
            mcand[1]    = ops.simd.mcand1;
            mplier[1]   = ops.simd.mplier1;
            mcand[2]    = simd_ops[31:24];
            mplier[2]   = simd_ops[23:16];
            mcand[3]    = simd_ops[15:8];
            mplier[3]   = simd_ops[7:0];
            lane_sgn[0] = is_signed;
            lane_sgn[1] = simd_signed[1:0];
            lane_sgn[2] = simd_signed[3:2];
            lane_sgn[3] = simd_signed[5:4];
        end else begin
            mcand[0]    = ops.scalar.multiplicand[15:8];
            mplier[0]   = ops.scalar.multiplier[15:8];
            mcand[1]    = ops.scalar.multiplicand[15:8];
            mplier[1]   = ops.scalar.multiplier[7:0];
            mcand[2]    = ops.scalar.multiplicand[7:0];
            mplier[2]   = ops.scalar.multiplier[15:8];
            mcand[3]    = ops.scalar.multiplicand[7:0];
            mplier[3]   = ops.scalar.multiplier[7:0];
            // Only a high byte carries the sign of its 16-bit operand
            lane_sgn[0] = is_signed;
            lane_sgn[1] = {is_signed[1], 1'b0};
            lane_sgn[2] = {1'b0, is_signed[0]};
            lane_sgn[3] = 2'b00;
        end
    end

    // Mode of the running job, so later register writes cannot disturb it
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            job_simd   <= 1'b0;
            job_signed <= 2'b00;
        end else if (start) begin
            job_simd   <= is_simd;
            job_signed <= is_signed;
        end
    end

    for (genvar g = 0; g < `MUL_LANES; g++) begin : g_lane
        assign lanes[g].start        = start;
        assign lanes[g].multiplicand = mcand[g];
        assign lanes[g].multiplier   = mplier[g];
        assign lanes[g].is_signed    = lane_sgn[g];
        assign pp[g]                 = lanes[g].product;
        assign lane_done[g]          = lanes[g].finished;

        mul8 u_mul8 (
            .CLK  (CLK),
            .rst_n(rst_n),
            .lane (lanes[g])
        );
    end

    // A cross term is negative only if its lane saw a signed high byte
    assign cross_hl = {{8{job_signed[1] & pp[1][15]}}, pp[1], 8'b0};
    assign cross_lh = {{8{job_signed[0] & pp[2][15]}}, pp[2], 8'b0};
    assign scalar_sum = {pp[0], 16'b0} + cross_hl + cross_lh + {16'b0, pp[3]};

    assign product      = job_simd ? {pp[1], pp[0]} : scalar_sum;
    assign simd_product = {pp[3], pp[2]};
    assign finished     = &lane_done;     // Lanes run in lockstep

endmodule

`default_nettype wire

// ==== mul_apb_regs.sv ====
//----------------------------------------------------------------------------
// APB register block of the multiply unit
// Holds operands and mode, issues the start pulse and keeps the results
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "mul_macros.svh"

module mul_apb_regs (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [`MUL_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   start,
    output logic                   is_simd,
    output logic [1:0]             is_signed,
    output logic [5:0]             simd_signed,
    output mul_pkg::op_word_t      ops,
    output logic [31:0]            simd_ops,
    input  logic                   finished,
    input  logic [31:0]            product,
    input  logic [31:0]            simd_product
);

    logic        access;
    logic        mapped;
    logic        read_only;
    logic        wr_en;
    logic        start_req;
    logic        busy;
    logic        done;
    logic [31:0] result;
    logic [31:0] simd_result;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            `MUL_REG_CTRL, `MUL_REG_SIGN, `MUL_REG_OPS, `MUL_REG_SIMD_OPS: ;
            `MUL_REG_STATUS, `MUL_REG_RESULT, `MUL_REG_SIMD_RESULT: read_only = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign access    = psel & penable;
    assign wr_en     = access & pwrite & mapped & ~read_only;
    assign start_req = wr_en & (paddr == `MUL_REG_CTRL) & pwdata[0] & ~busy;  // Dropped when busy
    assign pready    = 1'b1;                                  // No wait states
    assign pslverr   = access & (~mapped | (pwrite & read_only));

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                `MUL_REG_CTRL:        prdata = {30'b0, is_simd, 1'b0};
                `MUL_REG_SIGN:        prdata = {24'b0, simd_signed, is_signed};
                `MUL_REG_OPS:         prdata = ops;
                `MUL_REG_SIMD_OPS:    prdata = simd_ops;
                `MUL_REG_STATUS:      prdata = {30'b0, done, busy};
                `MUL_REG_RESULT:      prdata = result;
                `MUL_REG_SIMD_RESULT: prdata = simd_result;
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            is_simd     <= 1'b0;
            is_signed   <= 2'b00;
            simd_signed <= 6'b0;
            ops         <= '0;
            simd_ops    <= '0;
        end else if (wr_en) begin
            case (paddr)
                `MUL_REG_CTRL: is_simd <= pwdata[1];
                `MUL_REG_SIGN: begin
                    is_signed   <= pwdata[1:0];
                    simd_signed <= pwdata[7:2];
                end
                `MUL_REG_OPS:      ops      <= pwdata;
                `MUL_REG_SIMD_OPS: simd_ops <= pwdata;
                default: ;
            endcase
        end
    end

    // Job state, results stay put until the next job completes
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            start       <= 1'b0;
            busy        <= 1'b0;
            done        <= 1'b0;
            result      <= '0;
            simd_result <= '0;
        end else begin
            start <= start_req;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy && finished) begin
                busy        <= 1'b0;
                done        <= 1'b1;
                result      <= product;
                simd_result <= simd_product;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mul_top.sv ====
//----------------------------------------------------------------------------
// APB multiply unit top level
// Register block in front of the four-lane vedic multiplier
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "mul_macros.svh"

module mul_top (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [`MUL_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    logic              start;
    logic              is_simd;
    logic [1:0]        is_signed;
    logic [5:0]        simd_signed;
    mul_pkg::op_word_t ops;
    logic [31:0]       simd_ops;
    logic              finished;
    logic [31:0]       product;
    logic [31:0]       simd_product;

    mul_apb_regs u_regs (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .start       (start),
        .is_simd     (is_simd),
        .is_signed   (is_signed),
        .simd_signed (simd_signed),
        .ops         (ops),
        .simd_ops    (simd_ops),
        .finished    (finished),
        .product     (product),
        .simd_product(simd_product)
    );

    vedic_mul16 u_mul (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .start       (start),
        .is_simd     (is_simd),
        .is_signed   (is_signed),
        .simd_signed (simd_signed),
        .ops         (ops),
        .simd_ops    (simd_ops),
        .finished    (finished),
        .product     (product),
        .simd_product(simd_product)
    );

endmodule

`default_nettype wire

// ==== tb_mul_checker.sv ====
//----------------------------------------------------------------------------
// APB watcher for the multiply unit testbench
// Tracks register writes and job timing, checks reads, pready and pslverr
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "mul_macros.svh"

module tb_mul_checker (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic [`MUL_ADDR_W-1:0] paddr,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [31:0]            pwdata,
    input  logic [31:0]            prdata,
    input  logic                   pready,
    input  logic                   pslverr,
    output int                     error_count
);

    localparam int JOB_EDGES = 3;      // Start edge to the edge where done rises

    mul_pkg::op_word_t ops_w;
    mul_pkg::op_word_t job_ops;
    logic [31:0]       simd_ops_w;
    logic [31:0]       job_simd_ops;
    logic [7:0]        sign_w;
    logic [7:0]        job_sign;
    logic              simd_w;
    logic              job_simd;
    logic              job_valid;      // Low until the first accepted start
    int                busy_cnt;
    logic              done_m;
    logic              busy_seen;
    logic              done_seen;
    logic              accepted;
    logic              err_exp;
    logic [63:0]       expected;
    int                errors = 0;

    assign error_count = errors;

    function automatic logic [15:0] lane_ref(input logic [7:0] a, input logic [7:0] b,
                                             input logic [1:0] sgn);
        logic signed [31:0] xa;
        logic signed [31:0] xb;
        logic signed [31:0] p;
        xa = sgn[1] ? {{24{a[7]}}, a} : {24'b0, a};
        xb = sgn[0] ? {{24{b[7]}}, b} : {24'b0, b};
        p  = xa * xb;
        return p[15:0];
    endfunction

    function automatic logic [31:0] scalar_ref(input logic [15:0] a, input logic [15:0] b,
                                               input logic [1:0] sgn);
        logic signed [63:0] xa;
        logic signed [63:0] xb;
        logic signed [63:0] p;
        xa = sgn[1] ? {{48{a[15]}}, a} : {48'b0, a};
        xb = sgn[0] ? {{48{b[15]}}, b} : {48'b0, b};
        p  = xa * xb;
        return p[31:0];
    endfunction

    // Upper half is SIMD_RESULT, lower half is RESULT
    function automatic logic [63:0] expected_results(input mul_pkg::op_word_t ops,
                                                     input logic [31:0] sops,
                                                     input logic [7:0] sgn,
                                                     input logic simd);
        logic [63:0] r;
        r = '0;
        if (simd) begin
            r[15:0]  = lane_ref(ops.simd.mcand0, ops.simd.mplier0, sgn[1:0]);
            r[31:16] = lane_ref(ops.simd.mcand1, ops.simd.mplier1, sgn[3:2]);
            r[47:32] = lane_ref(sops[31:24], sops[23:16], sgn[5:4]);
            r[63:48] = lane_ref(sops[15:8], sops[7:0], sgn[7:6]);
        end else begin
            r[31:0] = scalar_ref(ops.scalar.multiplicand, ops.scalar.multiplier, sgn[1:0]);
        end
        return r;
    endfunction

    function automatic logic bad_access(input logic [`MUL_ADDR_W-1:0] addr, input logic wr);
        case (addr)
            `MUL_REG_CTRL, `MUL_REG_SIGN, `MUL_REG_OPS, `MUL_REG_SIMD_OPS: return 1'b0;
            `MUL_REG_STATUS, `MUL_REG_RESULT, `MUL_REG_SIMD_RESULT:      return wr;
            default:                                                     return 1'b1;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] time %0t: %s expected %h, got %h", $time, what, exp, act);
            errors++;
        end
    endtask

    task automatic print_summary(input int timeouts);
        $display("Checker summary: %0d errors, %0d timeouts", errors, timeouts);
    endtask

    always @(posedge CLK) begin
        if (!rst_n) begin
            ops_w      = '0;
            simd_ops_w = '0;
            sign_w     = '0;
            simd_w     = 1'b0;
            job_simd   = 1'b0;
            job_valid  = 1'b0;
            busy_cnt   = 0;
            done_m     = 1'b0;
        end else begin
            busy_seen = (busy_cnt != 0);   // STATUS as seen before this edge
            done_seen = done_m;
            accepted  = 1'b0;
            if (psel && penable) begin
                check_value("pready", 32'h1, {31'b0, pready});   // No wait states
            end
            if (psel && penable && pready) begin
                err_exp = bad_access(paddr, pwrite);
                check_value("pslverr", {31'b0, err_exp}, {31'b0, pslverr});
                if (pwrite && !err_exp) begin
                    case (paddr)
                        `MUL_REG_CTRL: begin
                            simd_w   = pwdata[1];
                            accepted = pwdata[0] && !busy_seen;
                        end
                        `MUL_REG_SIGN:     sign_w     = pwdata[7:0];
                        `MUL_REG_OPS:      ops_w      = pwdata;
                        `MUL_REG_SIMD_OPS: simd_ops_w = pwdata;
                        default: ;
                    endcase
                end else if (!pwrite) begin
                    expected = job_valid ?
                               expected_results(job_ops, job_simd_ops, job_sign, job_simd) : '0;
                    case (paddr)
                        `MUL_REG_STATUS: check_value("STATUS", {30'b0, done_seen, busy_seen},
                                                     prdata);
                        `MUL_REG_RESULT: check_value("RESULT", expected[31:0], prdata);
                        `MUL_REG_SIMD_RESULT: begin
                            if (!job_valid || job_simd) begin
                                check_value("SIMD_RESULT", expected[63:32], prdata);
                            end
                        end
                        default: ;
                    endcase
                end
            end
            if (accepted) begin
                job_ops      = ops_w;      // Operands and mode of the new job
                job_simd_ops = simd_ops_w;
                job_sign     = sign_w;
                job_simd     = simd_w;
                job_valid    = 1'b1;
                busy_cnt     = JOB_EDGES;
                done_m       = 1'b0;
            end else if (busy_cnt != 0) begin
                busy_cnt--;
                if (busy_cnt == 0) begin
                    done_m = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_mul_top.sv ====
//----------------------------------------------------------------------------
// Testbench for the APB multiply unit
// Runs scalar, signed, SIMD, busy-start and bus error accesses over APB
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none
`include "mul_macros.svh"

module tb_mul_top;

    localparam int          POLL_LIMIT   = 16;      // STATUS reads before giving up
    localparam int          PREADY_LIMIT = 8;
    localparam logic [31:0] SEED         = 32'h568c;

    logic                   CLK;
    logic                   rst_n;
    logic [`MUL_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    int                     error_count;
    int                     timeout_count;
    logic [31:0]            lfsr;

    always #20 CLK = ~CLK;

    mul_top u_dut (
        .CLK(CLK), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    tb_mul_checker u_chk (
        .CLK(CLK), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .error_count(error_count)
    );

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic bus_access(input logic wr, input logic [`MUL_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge CLK);
        psel    = 1'b1;                 // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge CLK);
        penable = 1'b1;
        @(posedge CLK);
        while (!pready && waited < PREADY_LIMIT) begin
            @(posedge CLK);
            waited++;
        end
        rdata = prdata;
        if (!pready) begin
            $display("Timeout: no pready on access to offset %h after %0d cycles",
                     addr, PREADY_LIMIT);
            timeout_count++;
        end
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [`MUL_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input logic [`MUL_ADDR_W-1:0] addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            read_reg(`MUL_REG_STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            $display("Timeout: done not set after %0d STATUS reads", POLL_LIMIT);
            timeout_count++;
        end
    endtask

    task automatic run_scalar(input logic [15:0] a, input logic [15:0] b);
        logic [31:0] rd;
        write_reg(`MUL_REG_OPS, {a, b});
        write_reg(`MUL_REG_CTRL, 32'h1);
        wait_done();
        read_reg(`MUL_REG_RESULT, rd);   // The checker compares every result read
    endtask

    task automatic run_simd(input logic [7:0] sgn, input logic [31:0] ops,
                            input logic [31:0] sops);
        logic [31:0] rd;
        write_reg(`MUL_REG_SIGN, {24'b0, sgn});
        write_reg(`MUL_REG_OPS, ops);
        write_reg(`MUL_REG_SIMD_OPS, sops);
        write_reg(`MUL_REG_CTRL, 32'h3);
        wait_done();
        read_reg(`MUL_REG_RESULT, rd);
        read_reg(`MUL_REG_SIMD_RESULT, rd);
    endtask

    initial begin
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        logic [31:0] rnd_c;
        logic [31:0] rd;
        CLK           = 1'b0;
        rst_n         = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        lfsr          = SEED;
        timeout_count = 0;
        repeat (2) @(negedge CLK);
        rst_n = 1'b1;

        read_reg(`MUL_REG_STATUS, rd);                 // Everything zero after reset
        read_reg(`MUL_REG_RESULT, rd);
        read_reg(`MUL_REG_SIMD_RESULT, rd);

        write_reg(`MUL_REG_SIGN, 32'h0);
        run_scalar(16'hFFFF, 16'hFFFF);
        run_scalar(16'h0000, 16'h1234);
        run_scalar(16'hBEEF, 16'h0000);
        for (int i = 0; i < 5; i++) begin
            random_bits(32, rnd_a);
            run_scalar(rnd_a[31:16], rnd_a[15:0]);
        end

        // Every sign setting, with -32768 and -1 among the operands
        for (int s = 0; s < 4; s++) begin
            write_reg(`MUL_REG_SIGN, s);
            run_scalar(16'h8000, 16'hFFFF);
            run_scalar(16'hFFFF, 16'h8000);
            run_scalar(16'h8000, 16'h8000);
            for (int i = 0; i < 3; i++) begin
                random_bits(32, rnd_a);
                run_scalar(rnd_a[31:16], rnd_a[15:0]);
            end
        end

        run_simd(8'hFF, 32'h80FF_8080, 32'hFF7F_0080);
        for (int i = 0; i < 8; i++) begin
            random_bits(8, rnd_a);
            random_bits(32, rnd_b);
            random_bits(32, rnd_c);
            run_simd(rnd_a[7:0], rnd_b, rnd_c);
        end

        write_reg(`MUL_REG_SIGN, 32'h3);
        write_reg(`MUL_REG_OPS, 32'h8001_7FFF);
        write_reg(`MUL_REG_CTRL, 32'h1);
        write_reg(`MUL_REG_CTRL, 32'h3);               // Lands while busy, no new job
        wait_done();
        read_reg(`MUL_REG_RESULT, rd);
        write_reg(`MUL_REG_CTRL, 32'h3);
        read_reg(`MUL_REG_STATUS, rd);                 // done already cleared
        wait_done();
        read_reg(`MUL_REG_RESULT, rd);
        read_reg(`MUL_REG_SIMD_RESULT, rd);

        // Bus errors, then a clean access
        write_reg(`MUL_REG_STATUS, 32'h1);
        write_reg(`MUL_REG_RESULT, 32'hFFFF_FFFF);
        read_reg(5'h1C, rd);
        write_reg(5'h1C, 32'h5A5A_5A5A);
        read_reg(5'h02, rd);
        read_reg(`MUL_REG_SIGN, rd);
        read_reg(`MUL_REG_RESULT, rd);

        u_chk.print_summary(timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
mul_pkg.sv
lane_if.sv
mul8.sv
vedic_mul16.sv
mul_apb_regs.sv
mul_top.sv
tb_mul_checker.sv
tb_mul_top.sv

// ==== Bender.yml ====
package:
  name: vedic_mul_apb

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mul_pkg.sv
      - lane_if.sv
      - mul8.sv
      - vedic_mul16.sv
      - mul_apb_regs.sv
      - mul_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mul_checker.sv
      - tb_mul_top.sv
